// ==== Makefile ====
# Verilator build and run of the output stage testbench

VERILATOR ?= verilator
TOP       ?= output_vector_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= ** PASS **

SOURCES := $(wildcard source/*.sv) $(wildcard tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass line shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
source/ntm_arith_pkg.sv
source/ntm_ctrl_pkg.sv
source/operand_pair_if.sv
source/row_sum_if.sv
source/matrix_vector_product.sv
source/vector_summation.sv
source/output_vector.sv
source/ntm_output_vector_top.sv
tb/output_vector_tb.sv

// ==== source/matrix_vector_product.sv ====
`timescale 1ns/1ns

module matrix_vector_product #(
  parameter int DATA_SIZE = ntm_arith_pkg::DATA_SIZE_DEFAULT
) (
  input logic CLK,
  input logic RST,

  // Operand pairs from the sequencer
  operand_pair_if.sink pair,

  // Side information, sampled with the last pair of a row
  input logic [ntm_arith_pkg::SIZE_FIELD_WIDTH-1:0] row_index,
  input logic                                       phase_last,

  // Completed row sums
  row_sum_if.source sums
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  logic [DATA_SIZE-1:0] product;
  logic [DATA_SIZE-1:0] acc;
  logic [DATA_SIZE-1:0] row_total;
  logic                 close_row;

  ////////////////////////////////////////////////////////////
  // Multiply and add
  ////////////////////////////////////////////////////////////

  // Low DATA_SIZE bits only
  // Same bits for signed and unsigned operands
  assign product = pair.a * pair.b;

  // Running sum including the current pair, wraps on overflow
  assign row_total = acc + product;

  assign close_row = pair.enable && pair.row_last;

  // Accumulator and sum strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc         <= '0;
      sums.enable <= 1'b0;
    end else begin
      // Sum valid one cycle after the last pair of its row
      sums.enable <= close_row;

      if (pair.enable) begin
        if (pair.row_last) begin
          // Next row starts from zero
          // First pair of that row arrives no earlier than the next cycle
          acc <= '0;
        end else begin
          acc <= row_total;
        end
      end
    end
  end

  // Row sum payload, qualified by sums.enable
  always_ff @(posedge CLK) begin
    if (close_row) begin
      sums.sum   <= row_total;
      sums.index <= row_index;
      sums.last  <= phase_last;
    end
  end

endmodule

// ==== source/ntm_arith_pkg.sv ====
package ntm_arith_pkg;

  ////////////////////////////////////////////////////////////
  // Datapath words
  ////////////////////////////////////////////////////////////

  // Default width of the K, r, U, h and y elements
  // Values are two's complement
  // Products and sums wrap modulo 2^DATA_SIZE
  localparam int DATA_SIZE_DEFAULT = 16;

  ////////////////////////////////////////////////////////////
  // Size fields
  ////////////////////////////////////////////////////////////

  // Width of the size_y, size_w and size_l inputs
  // Row and column counters and row indices use the same width
  // Must hold the largest MAX_SIZE in use
  localparam int SIZE_FIELD_WIDTH = 8;

endpackage

// ==== source/ntm_ctrl_pkg.sv ====
package ntm_ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // Sequencer phase
  ////////////////////////////////////////////////////////////

  // IDLE waits for start
  // FIRST_PRODUCT streams K and r, row by row
  // SECOND_PRODUCT streams U and h, row by row
  // DRAIN waits for the last y element to leave the pipeline
  typedef enum logic [1:0] {
    IDLE           = 2'd0,
    FIRST_PRODUCT  = 2'd1,
    SECOND_PRODUCT = 2'd2,
    DRAIN          = 2'd3
  } phase_t;

  ////////////////////////////////////////////////////////////
  // Size limits
  ////////////////////////////////////////////////////////////

  // Default largest Y, W or L
  // Also the default depth of the row-sum buffer
  localparam int MAX_SIZE_DEFAULT = 16;

endpackage

// ==== source/ntm_output_vector_top.sv ====
`timescale 1ns/1ns

// y = K·r + U·h
module ntm_output_vector_top #(
  parameter int DATA_SIZE = ntm_arith_pkg::DATA_SIZE_DEFAULT,
  parameter int MAX_SIZE  = ntm_ctrl_pkg::MAX_SIZE_DEFAULT
) (
  input logic CLK,
  input logic RST,

  // Handshake
  input  logic start,
  output logic ready,
  output logic busy,

  // Sizes
  input logic [ntm_arith_pkg::SIZE_FIELD_WIDTH-1:0] size_y,
  input logic [ntm_arith_pkg::SIZE_FIELD_WIDTH-1:0] size_w,
  input logic [ntm_arith_pkg::SIZE_FIELD_WIDTH-1:0] size_l,

  // Operands
  input logic [DATA_SIZE-1:0] k_in,
  input logic [DATA_SIZE-1:0] r_in,
  input logic [DATA_SIZE-1:0] u_in,
  input logic [DATA_SIZE-1:0] h_in,
  input logic                 k_in_enable,
  input logic                 u_in_enable,

  // Result
  output logic [DATA_SIZE-1:0] y_out,
  output logic                 y_out_enable
);

  ////////////////////////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////////////////////////

  logic [ntm_arith_pkg::SIZE_FIELD_WIDTH-1:0] row_index;
  logic                                       phase_last;
  ntm_ctrl_pkg::phase_t                       phase;
  logic                                       y_last;

  operand_pair_if #(.DATA_SIZE(DATA_SIZE)) pair_bus ();
  row_sum_if      #(.DATA_SIZE(DATA_SIZE)) sum_bus ();

  // Sequencer
  output_vector #(
    .DATA_SIZE(DATA_SIZE),
    .MAX_SIZE (MAX_SIZE)
  ) i_output_vector (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .ready      (ready),
    .busy       (busy),
    .size_y     (size_y),
    .size_w     (size_w),
    .size_l     (size_l),
    .k_in       (k_in),
    .r_in       (r_in),
    .u_in       (u_in),
    .h_in       (h_in),
    .k_in_enable(k_in_enable),
    .u_in_enable(u_in_enable),
    .pair       (pair_bus.source),
    .row_index  (row_index),
    .phase_last (phase_last),
    .phase      (phase),
    .y_last     (y_last)
  );

  // Row dot products
  matrix_vector_product #(
    .DATA_SIZE(DATA_SIZE)
  ) i_matrix_vector_product (
    .CLK       (CLK),
    .RST       (RST),
    .pair      (pair_bus.sink),
    .row_index (row_index),
    .phase_last(phase_last),
    .sums      (sum_bus.source)
  );

  // K·r buffer and final addition
  vector_summation #(
    .DATA_SIZE(DATA_SIZE),
    .MAX_SIZE (MAX_SIZE)
  ) i_vector_summation (
    .CLK         (CLK),
    .RST         (RST),
    .phase       (phase),
    .sums        (sum_bus.sink),
    .y_out       (y_out),
    .y_out_enable(y_out_enable),
    .y_last      (y_last)
  );

endmodule

// ==== source/operand_pair_if.sv ====
`timescale 1ns/1ns

// Operand pairs from the sequencer to the MAC unit
// One pair per enable, rows back to back
interface operand_pair_if #(
  parameter int DATA_SIZE = ntm_arith_pkg::DATA_SIZE_DEFAULT
);

  // Matrix element, K or U
  logic [DATA_SIZE-1:0] a;
  // Vector element, r or h
  logic [DATA_SIZE-1:0] b;

  // One strobe per accepted pair
  logic enable;
  // Final pair of the current row
  logic row_last;

  // Sequencer side
  modport source (
    output a,
    output b,
    output enable,
    output row_last
  );

  // MAC side
  modport sink (
    input a,
    input b,
    input enable,
    input row_last
  );

endinterface

// ==== source/output_vector.sv ====
`timescale 1ns/1ns

module output_vector #(
  parameter int DATA_SIZE = ntm_arith_pkg::DATA_SIZE_DEFAULT,
  parameter int MAX_SIZE  = ntm_ctrl_pkg::MAX_SIZE_DEFAULT
) (
  input logic CLK,
  input logic RST,

  // Host handshake
  input  logic start,
  output logic ready,
  output logic busy,

  // Problem sizes, sampled with start
  input logic [ntm_arith_pkg::SIZE_FIELD_WIDTH-1:0] size_y,
  input logic [ntm_arith_pkg::SIZE_FIELD_WIDTH-1:0] size_w,
  input logic [ntm_arith_pkg::SIZE_FIELD_WIDTH-1:0] size_l,

  // Operand streams
  input logic [DATA_SIZE-1:0] k_in,
  input logic [DATA_SIZE-1:0] r_in,
  input logic [DATA_SIZE-1:0] u_in,
  input logic [DATA_SIZE-1:0] h_in,
  input logic                 k_in_enable,
  input logic                 u_in_enable,

  // Pairs to the MAC unit
  operand_pair_if.source pair,

  // Side information for the MAC unit
  output logic [ntm_arith_pkg::SIZE_FIELD_WIDTH-1:0] row_index,
  output logic                                       phase_last,
  output ntm_ctrl_pkg::phase_t                       phase,

  // Final y element leaves the summation unit
  input logic y_last
);

  ////////////////////////////////////////////////////////////
  // Constants and signals
  ////////////////////////////////////////////////////////////

  localparam int SW = ntm_arith_pkg::SIZE_FIELD_WIDTH;

  localparam logic [SW-1:0] SIZE_ONE = SW'(1);
  localparam logic [SW-1:0] SIZE_MAX = SW'(MAX_SIZE);

  // Sizes of the current run
  logic [SW-1:0] size_y_q;
  logic [SW-1:0] size_w_q;
  logic [SW-1:0] size_l_q;

  // Position inside the current matrix
  logic [SW-1:0] col_cnt;
  logic [SW-1:0] row_cnt;

  logic [SW-1:0] row_width;
  logic          in_second;
  logic          accept;
  logic          col_last;
  logic          row_final;

  // Keeps a bad size from running past the row-sum buffer
  function automatic logic [SW-1:0] clamp_size(input logic [SW-1:0] size);
    logic [SW-1:0] result;
    result = size;
    if (size == '0) begin
      result = SIZE_ONE;
    end else if (size > SIZE_MAX) begin
      result = SIZE_MAX;
    end
    return result;
  endfunction

  ////////////////////////////////////////////////////////////
  // Strobe selection
  ////////////////////////////////////////////////////////////

  assign in_second = (phase == ntm_ctrl_pkg::SECOND_PRODUCT);

  // Strobes outside their own phase are dropped
  assign accept = ((phase == ntm_ctrl_pkg::FIRST_PRODUCT) && k_in_enable) ||
                  (in_second && u_in_enable);

  // Row length is W for K and L for U
  assign row_width = in_second ? size_l_q : size_w_q;
  assign col_last  = (col_cnt == row_width - SIZE_ONE);
  assign row_final = (row_cnt == size_y_q - SIZE_ONE);

  // Pair goes out on the strobe cycle itself
  assign pair.a        = in_second ? u_in : k_in;
  assign pair.b        = in_second ? h_in : r_in;
  assign pair.enable   = accept;
  assign pair.row_last = accept && col_last;

  assign row_index  = row_cnt;
  assign phase_last = row_final;

  ////////////////////////////////////////////////////////////
  // Phase FSM and counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      phase    <= ntm_ctrl_pkg::IDLE;
      ready    <= 1'b0;
      busy     <= 1'b0;
      size_y_q <= SIZE_ONE;
      size_w_q <= SIZE_ONE;
      size_l_q <= SIZE_ONE;
      col_cnt  <= '0;
      row_cnt  <= '0;
    end else begin
      // Single-cycle pulse
      ready <= 1'b0;

      case (phase)
        ntm_ctrl_pkg::IDLE: begin
          if (start) begin
            size_y_q <= clamp_size(size_y);
            size_w_q <= clamp_size(size_w);
            size_l_q <= clamp_size(size_l);
            col_cnt  <= '0;
            row_cnt  <= '0;
            busy     <= 1'b1;
            phase    <= ntm_ctrl_pkg::FIRST_PRODUCT;
          end
        end

        ntm_ctrl_pkg::FIRST_PRODUCT,
        ntm_ctrl_pkg::SECOND_PRODUCT: begin
          if (accept) begin
            if (col_last) begin
              col_cnt <= '0;
              if (row_final) begin
                row_cnt <= '0;
                // K done, U strobes accepted from the next cycle on
                if (in_second) begin
                  phase <= ntm_ctrl_pkg::DRAIN;
                end else begin
                  phase <= ntm_ctrl_pkg::SECOND_PRODUCT;
                end
              end else begin
                row_cnt <= row_cnt + SIZE_ONE;
              end
            end else begin
              col_cnt <= col_cnt + SIZE_ONE;
            end
          end
        end

        ntm_ctrl_pkg::DRAIN: begin
          // Ready one cycle after the final y element
          if (y_last) begin
            ready <= 1'b1;
            busy  <= 1'b0;
            phase <= ntm_ctrl_pkg::IDLE;
          end
        end

        default: begin
          phase <= ntm_ctrl_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

// ==== source/row_sum_if.sv ====
`timescale 1ns/1ns

// Finished row sums from the MAC unit to the summation unit
// Index and last travel with the sum they belong to
interface row_sum_if #(
  parameter int DATA_SIZE = ntm_arith_pkg::DATA_SIZE_DEFAULT
);

  // Dot product of one matrix row with the vector
  logic [DATA_SIZE-1:0] sum;
  // Valid for one cycle per row
  logic enable;
  // Row number y
  logic [ntm_arith_pkg::SIZE_FIELD_WIDTH-1:0] index;
  // Final row of the phase that produced it
  logic last;

  // MAC side
  modport source (
    output sum,
    output enable,
    output index,
    output last
  );

  // Summation side
  modport sink (
    input sum,
    input enable,
    input index,
    input last
  );

endinterface

// ==== source/vector_summation.sv ====
`timescale 1ns/1ns

module vector_summation #(
  parameter int DATA_SIZE = ntm_arith_pkg::DATA_SIZE_DEFAULT,
  parameter int MAX_SIZE  = ntm_ctrl_pkg::MAX_SIZE_DEFAULT
) (
  input logic CLK,
  input logic RST,

  // Current sequencer phase
  input ntm_ctrl_pkg::phase_t phase,

  // Row sums from the MAC unit
  row_sum_if.sink sums,

  // Output vector y
  output logic [DATA_SIZE-1:0] y_out,
  output logic                 y_out_enable,
  output logic                 y_last
);

  ////////////////////////////////////////////////////////////
  // Constants and signals
  ////////////////////////////////////////////////////////////

  // Buffer address width, at least one bit
  localparam int ADDR_WIDTH = (MAX_SIZE > 1) ? $clog2(MAX_SIZE) : 1;

  // Phase in which the incoming row sum was produced
  ntm_ctrl_pkg::phase_t sum_phase;

  logic [ADDR_WIDTH-1:0] addr;
  logic                  store_first;
  logic                  add_second;

  // Phase-one row sums, one entry per row of K
  logic [DATA_SIZE-1:0] row_buf [MAX_SIZE];

  ////////////////////////////////////////////////////////////
  // Phase alignment
  ////////////////////////////////////////////////////////////

  // Row sums trail their last strobe by one cycle
  // The last sum of a phase arrives after the sequencer has moved on,
  // so the phase is delayed by the same cycle
  assign store_first = sums.enable && (sum_phase == ntm_ctrl_pkg::FIRST_PRODUCT);
  assign add_second  = sums.enable && (sum_phase == ntm_ctrl_pkg::SECOND_PRODUCT);

  // Index never exceeds MAX_SIZE-1
  assign addr = sums.index[ADDR_WIDTH-1:0];

  // Control registers
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sum_phase    <= ntm_ctrl_pkg::IDLE;
      y_out_enable <= 1'b0;
      y_last       <= 1'b0;
    end else begin
      sum_phase <= phase;

      // One output per phase-two row sum
      y_out_enable <= add_second;
      // Final row of phase two closes the vector
      y_last       <= add_second && sums.last;
    end
  end

  ////////////////////////////////////////////////////////////
  // Buffer and output word
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    // K·r row sums wait here for phase two
    if (store_first) begin
      row_buf[addr] <= sums.sum;
    end

    // U·h row sum plus the stored K·r sum, wraps on overflow
    if (add_second) begin
      y_out <= row_buf[addr] + sums.sum;
    end
  end

endmodule

// ==== tb/output_vector_tb.sv ====
`timescale 1ns/1ns

module output_vector_tb;

  ////////////////////////////////////////////////////////////
  // Configuration
  ////////////////////////////////////////////////////////////

  localparam int DATA_SIZE = 16;
  localparam int MAX_SIZE  = 8;
  localparam int SW        = ntm_arith_pkg::SIZE_FIELD_WIDTH;

  // Longest gap between strobes in any test
  localparam int MAX_GAP = 3;
  // 4 random, 4 back-to-back, 4 extreme, 30 repeated
  localparam int RUNS        = 42;
  localparam int CYCLE_LIMIT = RUNS * (2 * MAX_SIZE * MAX_SIZE * (1 + MAX_GAP) + 20);

  logic                 CLK;
  logic                 RST;
  logic                 start;
  logic                 ready;
  logic                 busy;
  logic [SW-1:0]        size_y;
  logic [SW-1:0]        size_w;
  logic [SW-1:0]        size_l;
  logic [DATA_SIZE-1:0] k_in;
  logic [DATA_SIZE-1:0] r_in;
  logic [DATA_SIZE-1:0] u_in;
  logic [DATA_SIZE-1:0] h_in;
  logic                 k_in_enable;
  logic                 u_in_enable;
  logic [DATA_SIZE-1:0] y_out;
  logic                 y_out_enable;

  // Flags the last U strobe of a row for the monitor
  logic u_row_end;

  // Operands of the current run
  logic [DATA_SIZE-1:0] k_mat [MAX_SIZE*MAX_SIZE];
  logic [DATA_SIZE-1:0] u_mat [MAX_SIZE*MAX_SIZE];
  logic [DATA_SIZE-1:0] r_vec [MAX_SIZE];
  logic [DATA_SIZE-1:0] h_vec [MAX_SIZE];

  // Expected y words, last flags and arrival cycles
  logic [DATA_SIZE-1:0] exp_q [$];
  bit                   last_q [$];
  int                   due_q [$];

  logic [DATA_SIZE-1:0] exp_word;
  bit                   exp_last;
  int                   exp_cycle;
  int                   ncount;
  int                   ready_due;
  int                   run_outputs;
  int                   cur_size_y;
  bit                   ready_seen;
  bit                   idle_expected;
  string                test_name;

  ntm_output_vector_top #(
    .DATA_SIZE(DATA_SIZE),
    .MAX_SIZE (MAX_SIZE)
  ) i_dut (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .ready       (ready),
    .busy        (busy),
    .size_y      (size_y),
    .size_w      (size_w),
    .size_l      (size_l),
    .k_in        (k_in),
    .r_in        (r_in),
    .u_in        (u_in),
    .h_in        (h_in),
    .k_in_enable (k_in_enable),
    .u_in_enable (u_in_enable),
    .y_out       (y_out),
    .y_out_enable(y_out_enable)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////
  // Error handling
  ////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("** FAIL **");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string what, input int expected, input int actual);
    assert (expected == actual) else begin
      $display("[FAIL] %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
      stop_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Plain random word, or one near the ends of the signed range
  function automatic logic [DATA_SIZE-1:0] draw_operand(input bit extremes);
    logic [DATA_SIZE-1:0] word;
    word = DATA_SIZE'($urandom);
    if (extremes) begin
      case ($urandom_range(3, 0))
        0:       word = {1'b1, {(DATA_SIZE-1){1'b0}}};
        1:       word = {1'b0, {(DATA_SIZE-1){1'b1}}};
        2:       word = '1;
        default: word = {1'b1, {(DATA_SIZE-2){1'b0}}, 1'b1};
      endcase
    end
    return word;
  endfunction

  // One cycle with no real pair
  // Stray strobes carry junk data
  task automatic idle_cycle(input bit stray_k, input bit stray_u);
    @(posedge CLK);
    start       <= 1'b0;
    k_in_enable <= stray_k;
    u_in_enable <= stray_u;
    u_row_end   <= 1'b0;
    k_in        <= DATA_SIZE'($urandom);
    r_in        <= DATA_SIZE'($urandom);
    u_in        <= DATA_SIZE'($urandom);
    h_in        <= DATA_SIZE'($urandom);
  endtask

  // Random gap with strobes of the other phase mixed in
  task automatic gap_cycles(input int gap_max, input bit second);
    int n;
    n = $urandom_range(gap_max, 0);
    repeat (n) begin
      if (second) begin
        idle_cycle(1'($urandom_range(1, 0)), 1'b0);
      end else begin
        idle_cycle(1'b0, 1'($urandom_range(1, 0)));
      end
    end
  endtask

  task automatic drive_pair(input bit second, input logic [DATA_SIZE-1:0] a,
                            input logic [DATA_SIZE-1:0] b, input bit row_end);
    @(posedge CLK);
    start       <= 1'b0;
    k_in_enable <= !second;
    u_in_enable <= second;
    u_row_end   <= row_end;
    if (second) begin
      u_in <= a;
      h_in <= b;
    end else begin
      k_in <= a;
      r_in <= b;
    end
  endtask

  // Random sizes and operands, model, then both phases and the wait for ready
  task automatic run_once(input int gap_max, input bit extremes);
    int     sy;
    int     sw;
    int     sl;
    longint total;
    sy = $urandom_range(MAX_SIZE, 1);
    sw = $urandom_range(MAX_SIZE, 1);
    sl = $urandom_range(MAX_SIZE, 1);
    for (int i = 0; i < MAX_SIZE * MAX_SIZE; i++) begin
      k_mat[i] = draw_operand(extremes);
      u_mat[i] = draw_operand(extremes);
    end
    for (int i = 0; i < MAX_SIZE; i++) begin
      r_vec[i] = draw_operand(extremes);
      h_vec[i] = draw_operand(extremes);
    end

    // Exact signed sums
    // Only the low DATA_SIZE bits count at the end
    for (int y = 0; y < sy; y++) begin
      total = 0;
      for (int w = 0; w < sw; w++) begin
        total += longint'($signed(k_mat[y*MAX_SIZE+w])) * longint'($signed(r_vec[w]));
      end
      for (int l = 0; l < sl; l++) begin
        total += longint'($signed(u_mat[y*MAX_SIZE+l])) * longint'($signed(h_vec[l]));
      end
      exp_q.push_back(total[DATA_SIZE-1:0]);
      last_q.push_back(y == sy - 1);
    end

    cur_size_y  = sy;
    run_outputs = 0;
    ready_seen  = 1'b0;
    ready_due   = -1;

    @(posedge CLK);
    idle_expected = 1'b0;
    start       <= 1'b1;
    size_y      <= SW'(sy);
    size_w      <= SW'(sw);
    size_l      <= SW'(sl);
    k_in_enable <= 1'b0;
    u_in_enable <= 1'b0;
    u_row_end   <= 1'b0;

    // Phase one streams K and r row by row
    for (int y = 0; y < sy; y++) begin
      for (int w = 0; w < sw; w++) begin
        gap_cycles(gap_max, 1'b0);
        drive_pair(1'b0, k_mat[y*MAX_SIZE+w], r_vec[w], 1'b0);
      end
    end
    // Phase two streams U and h
    for (int y = 0; y < sy; y++) begin
      for (int l = 0; l < sl; l++) begin
        gap_cycles(gap_max, 1'b1);
        drive_pair(1'b1, u_mat[y*MAX_SIZE+l], h_vec[l], l == sl - 1);
      end
    end

    while (!ready_seen) begin
      idle_cycle(1'b0, 1'b0);
    end
    // Idle with stray strobes on both sides
    idle_expected = 1'b1;
    repeat ($urandom_range(4, 1)) begin
      idle_cycle(1'($urandom_range(1, 0)), 1'($urandom_range(1, 0)));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Output monitor on the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (!RST) begin
      ncount = ncount + 1;
      assert (ncount <= CYCLE_LIMIT) else begin
        $display("Timeout: the unit hung, %0d cycles passed before all runs ended", ncount);
        stop_run();
      end

      // Row end strobe now and its y element two cycles later
      if (u_in_enable && u_row_end) begin
        due_q.push_back(ncount + 2);
      end

      if (idle_expected) begin
        check_value("busy while idle", 0, int'(busy));
      end else if (!start && !ready) begin
        // High from the cycle after start until the ready pulse
        check_value("busy during run", 1, int'(busy));
      end

      check_value("ready pulse", int'(ncount == ready_due), int'(ready));
      if (ready) begin
        ready_seen = 1'b1;
        check_value("outputs per run", cur_size_y, run_outputs);
      end

      if (y_out_enable) begin
        assert (exp_q.size() > 0 && due_q.size() > 0) else begin
          $display("An output strobe arrived with no row outstanding");
          stop_run();
        end
        exp_word    = exp_q.pop_front();
        exp_last    = last_q.pop_front();
        exp_cycle   = due_q.pop_front();
        run_outputs = run_outputs + 1;
        check_value("y_out", int'($signed(exp_word)), int'($signed(y_out)));
        check_value("output cycle", exp_cycle, ncount);
        check_value("y_last", int'(exp_last), int'(i_dut.y_last));
        // Ready one cycle after the final element
        if (exp_last) begin
          ready_due = ncount + 1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(78));
    RST           = 1'b1;
    start         = 1'b0;
    size_y        = SW'(1);
    size_w        = SW'(1);
    size_l        = SW'(1);
    k_in          = '0;
    r_in          = '0;
    u_in          = '0;
    h_in          = '0;
    k_in_enable   = 1'b0;
    u_in_enable   = 1'b0;
    u_row_end     = 1'b0;
    ncount        = 0;
    ready_due     = -1;
    run_outputs   = 0;
    cur_size_y    = 0;
    ready_seen    = 1'b0;
    idle_expected = 1'b0;
    test_name     = "reset";

    repeat (8) @(posedge CLK);
    RST <= 1'b0;
    idle_expected = 1'b1;
    repeat (4) idle_cycle(1'b1, 1'b1);

    test_name = "random gaps";
    repeat (4) run_once(MAX_GAP, 1'b0);
    test_name = "back-to-back";
    repeat (4) run_once(0, 1'b0);
    test_name = "extreme operands";
    repeat (4) run_once(1, 1'b1);
    test_name = "repeated runs";
    repeat (30) run_once(2, 1'b0);

    if (exp_q.size() == 0 && due_q.size() == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("Runs ended with %0d outputs still missing", exp_q.size());
      stop_run();
    end
  end

endmodule
